/* hdl/reg_bank_defs.svh */
/*
 * register bank widths and register map
 * reset values and device ID
 * access permission codes, one bit per mode
 */
`ifndef REG_BANK_DEFS_SVH
`define REG_BANK_DEFS_SVH

// ==============================
// bus widths
// ==============================
`define REG_AW          7
`define REG_DW          8
`define REG_NUM_CELLS   7

// ==============================
// register map
// ==============================
`define REG_ADDR_DEVICE_ID  7'h00
`define REG_ADDR_MODE       7'h01
`define REG_ADDR_CONFIG1    7'h02
`define REG_ADDR_CONFIG2    7'h03
`define REG_ADDR_STATUS1    7'h08
`define REG_ADDR_MASK1      7'h09
`define REG_ADDR_STATUS2    7'h0A
`define REG_ADDR_MASK2      7'h0B

// mode bit 0 low holds the bank in soft reset
`define REG_MODE_RST        8'h10
`define REG_CONFIG1_RST     8'h2B
`define REG_CONFIG2_RST     8'hFF
`define REG_MASK_RST        8'h00
`define REG_STATUS_RST      8'h00

`define REG_DEVICE_ID       8'hA3

// ==============================
// permissions {test, cfg, spi}
// ==============================
`define PERM_RW_CTRL_WR     3'b111
`define PERM_RW_CTRL_RD     3'b101
`define PERM_CFG_WR         3'b110
`define PERM_CFG_RD         3'b101
`define PERM_STATUS_WR      3'b011
`define PERM_STATUS_RD      3'b101
`define PERM_ID_RD          3'b101

`endif

/* hdl/reg_bus_pkg.sv */
/*
 * host bus types: request, response
 * access-mode enables and permission codes
 * permission check helper
 */
`include "reg_bank_defs.svh"

package reg_bus_pkg;

    // host request, 17 bits
    typedef struct packed {
        logic                ren;
        logic                wen;
        logic [`REG_AW-1:0]  addr;
        logic [`REG_DW-1:0]  wdata;
    } reg_req_t;

    // host response, 10 bits
    typedef struct packed {
        logic                wack;
        logic                rack;
        logic [`REG_DW-1:0]  rdata;
    } reg_rsp_t;

    // level enables from the access state
    typedef struct packed {
        logic test_en;
        logic cfg_en;
        logic spi_en;
    } reg_access_t;

    typedef struct packed {
        logic test;
        logic cfg;
        logic spi;
    } reg_perm_t;

    // any enabled mode that the register allows
    function automatic logic access_ok(input reg_perm_t perm, input reg_access_t acc);
        return (perm.test & acc.test_en) | (perm.cfg & acc.cfg_en) | (perm.spi & acc.spi_en);
    endfunction

endpackage

/* hdl/reg_map_pkg.sv */
/*
 * register content types
 * mode register fields
 * bundled register view for the inner logic
 */
`include "reg_bank_defs.svh"

package reg_map_pkg;

    typedef logic [`REG_DW-1:0] reg_word_t;

    // ==============================
    // mode register
    // ==============================
    // soft_run low keeps the rest of the bank in reset
    typedef struct packed {
        logic [6:0] op_mode;
        logic       soft_run;
    } mode_reg_t;

    // ==============================
    // register view, 56 bits
    // ==============================
    typedef struct packed {
        mode_reg_t  mode;
        reg_word_t  config1;
        reg_word_t  config2;
        // event flags, write 1 to clear
        reg_word_t  status1;
        reg_word_t  mask1;
        reg_word_t  status2;
        reg_word_t  mask2;
    } reg_out_t;

endpackage

/* hdl/reg_reset_merge.sv */
/*
 * bank reset from hard reset and soft-run bit
 * asserts at once, releases after two clock edges
 */
module reg_reset_merge (
    input  logic i_clk,
    input  logic i_arst_n,
    input  logic i_soft_run,
    output logic o_rst_n
);

    logic       merged_n;
    logic [1:0] sync_q;

    // either source pulls the bank into reset
    assign merged_n = i_arst_n & i_soft_run;

    always_ff @(posedge i_clk or negedge merged_n) begin
        if (!merged_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // release on second edge
    assign o_rst_n = sync_q[1];

endmodule

/* hdl/reg_rw_cell.sv */
/*
 * single read/write register
 * address match and permission gating
 * gated combinational read data
 */
`include "reg_bank_defs.svh"

module reg_rw_cell #(
    parameter logic [`REG_AW-1:0]     ADDR    = '0,
    parameter logic [`REG_DW-1:0]     RST_VAL = '0,
    parameter reg_bus_pkg::reg_perm_t WR_PERM = '0,
    parameter reg_bus_pkg::reg_perm_t RD_PERM = '0
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  reg_bus_pkg::reg_req_t     i_req,
    input  reg_bus_pkg::reg_access_t  i_access,
    output logic [`REG_DW-1:0]        o_value,
    output logic [`REG_DW-1:0]        o_rdata
);

    logic               hit;
    logic               wr_en;
    logic               rd_en;
    logic [`REG_DW-1:0] value_q;

    // ==============================
    // decode
    // ==============================
    assign hit   = (i_req.addr == ADDR);
    assign wr_en = i_req.wen & hit & reg_bus_pkg::access_ok(WR_PERM, i_access);
    assign rd_en = i_req.ren & hit & reg_bus_pkg::access_ok(RD_PERM, i_access);

    // ==============================
    // storage
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            value_q <= RST_VAL;
        end else if (wr_en) begin
            value_q <= i_req.wdata;
        end
    end

    assign o_value = value_q;

    // zero unless this cell is read and allowed
    assign o_rdata = rd_en ? value_q : '0;

endmodule

/* hdl/reg_rwc_cell.sv */
/*
 * single status register
 * event bits set, permitted write of 1 clears
 * gated combinational read data
 */
`include "reg_bank_defs.svh"

module reg_rwc_cell #(
    parameter logic [`REG_AW-1:0]     ADDR    = '0,
    parameter reg_bus_pkg::reg_perm_t WR_PERM = '0,
    parameter reg_bus_pkg::reg_perm_t RD_PERM = '0
) (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  reg_bus_pkg::reg_req_t     i_req,
    input  reg_bus_pkg::reg_access_t  i_access,
    input  logic [`REG_DW-1:0]        i_evt,
    output logic [`REG_DW-1:0]        o_value,
    output logic [`REG_DW-1:0]        o_rdata
);

    logic               hit;
    logic               wr_en;
    logic               rd_en;
    logic [`REG_DW-1:0] clr_mask;
    logic [`REG_DW-1:0] status_q;

    assign hit   = (i_req.addr == ADDR);
    assign wr_en = i_req.wen & hit & reg_bus_pkg::access_ok(WR_PERM, i_access);
    assign rd_en = i_req.ren & hit & reg_bus_pkg::access_ok(RD_PERM, i_access);

    // bits written as 1 are cleared
    assign clr_mask = wr_en ? i_req.wdata : '0;

    // ==============================
    // status flags
    // ==============================
    // event applied after clear, so a set in the same cycle wins
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            status_q <= `REG_STATUS_RST;
        end else begin
            status_q <= (status_q & ~clr_mask) | i_evt;
        end
    end

    assign o_value = status_q;
    assign o_rdata = rd_en ? status_q : '0;

endmodule

/* hdl/reg_read_mux.sv */
/*
 * read-only device ID
 * OR-combine of cell read data
 * registered read data, read and write acknowledges
 */
`include "reg_bank_defs.svh"

module reg_read_mux (
    input  logic                                    i_clk,
    input  logic                                    i_arst_n,
    input  reg_bus_pkg::reg_req_t                   i_req,
    input  reg_bus_pkg::reg_access_t                i_access,
    input  logic [`REG_NUM_CELLS-1:0][`REG_DW-1:0]  i_cell_rdata,
    output reg_bus_pkg::reg_rsp_t                   o_rsp
);

    logic               id_rd_en;
    logic [`REG_DW-1:0] id_rdata;
    logic [`REG_DW-1:0] cell_or;
    logic [`REG_DW-1:0] rdata_d;

    // ==============================
    // device ID
    // ==============================
    assign id_rd_en = i_req.ren & (i_req.addr == `REG_ADDR_DEVICE_ID) &
                      reg_bus_pkg::access_ok(`PERM_ID_RD, i_access);
    assign id_rdata = id_rd_en ? `REG_DEVICE_ID : '0;

    // cells drive zero when not selected
    always_comb begin
        cell_or = '0;
        for (int i = 0; i < `REG_NUM_CELLS; i++) begin
            cell_or = cell_or | i_cell_rdata[i];
        end
    end

    assign rdata_d = id_rdata | cell_or;

    // ==============================
    // response register
    // ==============================
    // hard reset only, acks keep running during soft reset
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_rsp.wack  <= 1'b0;
            o_rsp.rack  <= 1'b0;
            o_rsp.rdata <= '0;
        end else begin
            o_rsp.wack  <= i_req.wen;
            o_rsp.rack  <= i_req.ren;
            o_rsp.rdata <= rdata_d;
        end
    end

endmodule

/* hdl/reg_bank_top.sv */
/*
 * control register bank top level
 * reset merge, register cells, read path
 */
`include "reg_bank_defs.svh"

module reg_bank_top (
    input  logic                      i_clk,
    input  logic                      i_arst_n,
    input  reg_bus_pkg::reg_req_t     i_req,
    input  reg_bus_pkg::reg_access_t  i_access,
    input  logic [`REG_DW-1:0]        i_evt_status1,
    input  logic [`REG_DW-1:0]        i_evt_status2,
    output reg_bus_pkg::reg_rsp_t     o_rsp,
    output reg_map_pkg::reg_out_t     o_regs,
    output logic                      o_rst_n
);

    reg_map_pkg::mode_reg_t                mode_val;
    logic [`REG_DW-1:0]                    config1_val;
    logic [`REG_DW-1:0]                    config2_val;
    logic [`REG_DW-1:0]                    status1_val;
    logic [`REG_DW-1:0]                    mask1_val;
    logic [`REG_DW-1:0]                    status2_val;
    logic [`REG_DW-1:0]                    mask2_val;
    logic [`REG_NUM_CELLS-1:0][`REG_DW-1:0] cell_rdata;
    logic                                  bank_rst_n;

    // ==============================
    // reset
    // ==============================
    reg_reset_merge u_rst_merge (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_soft_run (mode_val.soft_run),
        .o_rst_n    (bank_rst_n)
    );

    assign o_rst_n = bank_rst_n;

    // mode sits on hard reset, it holds the soft reset bit
    reg_rw_cell #(
        .ADDR    (`REG_ADDR_MODE),
        .RST_VAL (`REG_MODE_RST),
        .WR_PERM (`PERM_RW_CTRL_WR),
        .RD_PERM (`PERM_RW_CTRL_RD)
    ) u_mode (
        .i_clk    (i_clk),
        .i_rst_n  (i_arst_n),
        .i_req    (i_req),
        .i_access (i_access),
        .o_value  (mode_val),
        .o_rdata  (cell_rdata[0])
    );

    // ==============================
    // configuration and mask
    // ==============================
    reg_rw_cell #(
        .ADDR    (`REG_ADDR_CONFIG1),
        .RST_VAL (`REG_CONFIG1_RST),
        .WR_PERM (`PERM_CFG_WR),
        .RD_PERM (`PERM_CFG_RD)
    ) u_config1 (
        .i_clk    (i_clk),
        .i_rst_n  (bank_rst_n),
        .i_req    (i_req),
        .i_access (i_access),
        .o_value  (config1_val),
        .o_rdata  (cell_rdata[1])
    );

    reg_rw_cell #(
        .ADDR    (`REG_ADDR_CONFIG2),
        .RST_VAL (`REG_CONFIG2_RST),
        .WR_PERM (`PERM_CFG_WR),
        .RD_PERM (`PERM_CFG_RD)
    ) u_config2 (
        .i_clk    (i_clk),
        .i_rst_n  (bank_rst_n),
        .i_req    (i_req),
        .i_access (i_access),
        .o_value  (config2_val),
        .o_rdata  (cell_rdata[2])
    );

    reg_rw_cell #(
        .ADDR    (`REG_ADDR_MASK1),
        .RST_VAL (`REG_MASK_RST),
        .WR_PERM (`PERM_CFG_WR),
        .RD_PERM (`PERM_CFG_RD)
    ) u_mask1 (
        .i_clk    (i_clk),
        .i_rst_n  (bank_rst_n),
        .i_req    (i_req),
        .i_access (i_access),
        .o_value  (mask1_val),
        .o_rdata  (cell_rdata[4])
    );

    reg_rw_cell #(
        .ADDR    (`REG_ADDR_MASK2),
        .RST_VAL (`REG_MASK_RST),
        .WR_PERM (`PERM_CFG_WR),
        .RD_PERM (`PERM_CFG_RD)
    ) u_mask2 (
        .i_clk    (i_clk),
        .i_rst_n  (bank_rst_n),
        .i_req    (i_req),
        .i_access (i_access),
        .o_value  (mask2_val),
        .o_rdata  (cell_rdata[6])
    );

    // ==============================
    // status
    // ==============================
    reg_rwc_cell #(
        .ADDR    (`REG_ADDR_STATUS1),
        .WR_PERM (`PERM_STATUS_WR),
        .RD_PERM (`PERM_STATUS_RD)
    ) u_status1 (
        .i_clk    (i_clk),
        .i_rst_n  (bank_rst_n),
        .i_req    (i_req),
        .i_access (i_access),
        .i_evt    (i_evt_status1),
        .o_value  (status1_val),
        .o_rdata  (cell_rdata[3])
    );

    reg_rwc_cell #(
        .ADDR    (`REG_ADDR_STATUS2),
        .WR_PERM (`PERM_STATUS_WR),
        .RD_PERM (`PERM_STATUS_RD)
    ) u_status2 (
        .i_clk    (i_clk),
        .i_rst_n  (bank_rst_n),
        .i_req    (i_req),
        .i_access (i_access),
        .i_evt    (i_evt_status2),
        .o_value  (status2_val),
        .o_rdata  (cell_rdata[5])
    );

    // read path on hard reset
    reg_read_mux u_read_mux (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_req        (i_req),
        .i_access     (i_access),
        .i_cell_rdata (cell_rdata),
        .o_rsp        (o_rsp)
    );

    assign o_regs = '{
        mode:    mode_val,
        config1: config1_val,
        config2: config2_val,
        status1: status1_val,
        mask1:   mask1_val,
        status2: status2_val,
        mask2:   mask2_val
    };

endmodule

/* bench/tb_reg_bank.sv */
/*
 * testbench for the control register bank
 * clock, reset, stimulus and register model
 * response checker on every read and write acknowledge
 */
`include "reg_bank_defs.svh"

module tb_reg_bank;

    logic                      i_clk;
    logic                      i_arst_n;
    reg_bus_pkg::reg_req_t     i_req;
    reg_bus_pkg::reg_access_t  i_access;
    logic [`REG_DW-1:0]        i_evt_status1;
    logic [`REG_DW-1:0]        i_evt_status2;
    reg_bus_pkg::reg_rsp_t     o_rsp;
    reg_map_pkg::reg_out_t     o_regs;
    logic                      o_rst_n;

    // model state indexed by the low address bits of mapped registers
    logic [7:0] model_q [0:15];
    logic       model_run;
    logic [7:0] exp_rdata;
    logic       prev_ren;
    logic       prev_wen;
    logic [7:0] prev_exp;
    int         checks;
    int         errors;
    integer     seed;

    reg_bank_top dut0 (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_req         (i_req),
        .i_access      (i_access),
        .i_evt_status1 (i_evt_status1),
        .i_evt_status2 (i_evt_status2),
        .o_rsp         (o_rsp),
        .o_regs        (o_regs),
        .o_rst_n       (o_rst_n)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // ==============================
    // reference model
    // ==============================
    function automatic logic [2:0] wr_perm_of(input logic [6:0] a);
        case (a)
            `REG_ADDR_MODE:                       return `PERM_RW_CTRL_WR;
            `REG_ADDR_CONFIG1, `REG_ADDR_CONFIG2: return `PERM_CFG_WR;
            `REG_ADDR_MASK1, `REG_ADDR_MASK2:     return `PERM_CFG_WR;
            `REG_ADDR_STATUS1, `REG_ADDR_STATUS2: return `PERM_STATUS_WR;
            default:                              return 3'b000;
        endcase
    endfunction

    function automatic logic [2:0] rd_perm_of(input logic [6:0] a);
        case (a)
            `REG_ADDR_DEVICE_ID:                  return `PERM_ID_RD;
            `REG_ADDR_MODE:                       return `PERM_RW_CTRL_RD;
            `REG_ADDR_CONFIG1, `REG_ADDR_CONFIG2: return `PERM_CFG_RD;
            `REG_ADDR_MASK1, `REG_ADDR_MASK2:     return `PERM_CFG_RD;
            `REG_ADDR_STATUS1, `REG_ADDR_STATUS2: return `PERM_STATUS_RD;
            default:                              return 3'b000;
        endcase
    endfunction

    function automatic logic permitted(input logic [2:0] perm, input logic [2:0] acc);
        return (perm & acc) != 3'b000;
    endfunction

    // per-bit status rule where an event beats a clear
    function automatic logic [7:0] status_next(input logic [7:0] cur, input logic [7:0] clr,
                                               input logic [7:0] evt);
        logic [7:0] nxt;
        nxt = cur;
        for (int b = 0; b < 8; b++) begin
            if (evt[b]) begin
                nxt[b] = 1'b1;
            end else if (clr[b]) begin
                nxt[b] = 1'b0;
            end
        end
        return nxt;
    endfunction

    // unmapped addresses have no read permission and fall out as 0
    function automatic logic [7:0] ref_read(input logic [6:0] a, input logic [2:0] acc);
        if (!permitted(rd_perm_of(a), acc)) begin
            return 8'h00;
        end
        if (a == `REG_ADDR_DEVICE_ID) begin
            return `REG_DEVICE_ID;
        end
        return model_q[a[3:0]];
    endfunction

    task automatic reset_model_bank();
        model_q[2]  = `REG_CONFIG1_RST;
        model_q[3]  = `REG_CONFIG2_RST;
        model_q[8]  = 8'h00;
        model_q[9]  = 8'h00;
        model_q[10] = 8'h00;
        model_q[11] = 8'h00;
        model_run   = 1'b0;
    endtask

    task automatic model_step(input logic wen, input logic [6:0] a, input logic [7:0] d,
                              input logic [2:0] acc, input logic [7:0] e1,
                              input logic [7:0] e2);
        logic [7:0] clr1;
        logic [7:0] clr2;
        logic       wr_ok;
        clr1  = 8'h00;
        clr2  = 8'h00;
        wr_ok = wen && permitted(wr_perm_of(a), acc);
        if (wr_ok) begin
            if (a == `REG_ADDR_MODE) begin
                model_q[1] = d;
            end else if (a == `REG_ADDR_STATUS1) begin
                clr1 = d;
            end else if (a == `REG_ADDR_STATUS2) begin
                clr2 = d;
            end else if (model_run) begin
                model_q[a[3:0]] = d;
            end
        end
        if (model_run) begin
            model_q[8]  = status_next(model_q[8], clr1, e1);
            model_q[10] = status_next(model_q[10], clr2, e2);
        end
        // soft reset lands after the same edge
        if (wr_ok && a == `REG_ADDR_MODE && !d[0]) begin
            reset_model_bank();
        end
    endtask

    // ==============================
    // checks
    // ==============================
    task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s = %02h, expected %02h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_regs();
        check_val("o_regs.mode", o_regs.mode, model_q[1]);
        check_val("o_regs.config1", o_regs.config1, model_q[2]);
        check_val("o_regs.config2", o_regs.config2, model_q[3]);
        check_val("o_regs.status1", o_regs.status1, model_q[8]);
        check_val("o_regs.mask1", o_regs.mask1, model_q[9]);
        check_val("o_regs.status2", o_regs.status2, model_q[10]);
        check_val("o_regs.mask2", o_regs.mask2, model_q[11]);
    endtask

    // response follows the request seen one negedge earlier
    always @(negedge i_clk) begin
        if (i_arst_n) begin
            check_val("o_rsp.rack", {7'b0, o_rsp.rack}, {7'b0, prev_ren});
            check_val("o_rsp.wack", {7'b0, o_rsp.wack}, {7'b0, prev_wen});
            if (prev_ren) begin
                check_val("o_rsp.rdata", o_rsp.rdata, prev_exp);
            end
        end
        prev_ren = i_req.ren;
        prev_wen = i_req.wen;
        prev_exp = exp_rdata;
    end

    task automatic wait_rst(input logic level);
        int n;
        n = 0;
        while (o_rst_n !== level && n < 20) begin
            @(negedge i_clk);
            n++;
        end
        checks++;
        assert (o_rst_n === level) else begin
            $display("timeout at %0t: o_rst_n never went to %0b", $time, level);
            errors++;
        end
    endtask

    // one request for one cycle then idle and compare the register view
    task automatic issue(input logic ren, input logic wen, input logic [6:0] a,
                         input logic [7:0] d, input logic [2:0] acc,
                         input logic [7:0] e1, input logic [7:0] e2);
        reg_bus_pkg::reg_req_t req;
        req.ren   = ren;
        req.wen   = wen;
        req.addr  = a;
        req.wdata = d;
        @(posedge i_clk);
        i_req         <= req;
        i_access      <= acc;
        i_evt_status1 <= e1;
        i_evt_status2 <= e2;
        exp_rdata = ref_read(a, acc);
        model_step(wen, a, d, acc, e1, e2);
        @(posedge i_clk);
        i_req         <= '0;
        i_evt_status1 <= 8'h00;
        i_evt_status2 <= 8'h00;
        @(negedge i_clk);
        check_regs();
    endtask

    task automatic end_test(input string name, input int err_start);
        $display("test %s: %0d errors", name, errors - err_start);
    endtask

    // ==============================
    // stimulus
    // ==============================
    initial begin
        logic [6:0] reg_addrs [0:6];
        logic [6:0] all_addrs [0:15];
        logic [31:0] r;
        logic [7:0]  d;
        logic [2:0]  acc;
        logic [6:0]  a;
        int          err_start;
        reg_addrs = '{`REG_ADDR_MODE, `REG_ADDR_CONFIG1, `REG_ADDR_CONFIG2,
                      `REG_ADDR_STATUS1, `REG_ADDR_MASK1, `REG_ADDR_STATUS2,
                      `REG_ADDR_MASK2};
        all_addrs = '{`REG_ADDR_DEVICE_ID, `REG_ADDR_MODE, `REG_ADDR_CONFIG1,
                      `REG_ADDR_CONFIG2, `REG_ADDR_STATUS1, `REG_ADDR_MASK1,
                      `REG_ADDR_STATUS2, `REG_ADDR_MASK2, 7'h05, 7'h7F,
                      `REG_ADDR_CONFIG1, `REG_ADDR_MASK1, `REG_ADDR_STATUS1,
                      `REG_ADDR_CONFIG2, `REG_ADDR_MASK2, `REG_ADDR_STATUS2};
        seed          = 7321;
        checks        = 0;
        errors        = 0;
        i_arst_n      = 1'b0;
        i_req         = '0;
        i_access      = '0;
        i_evt_status1 = 8'h00;
        i_evt_status2 = 8'h00;
        exp_rdata     = 8'h00;
        for (int i = 0; i < 16; i++) begin
            model_q[i] = 8'h00;
        end
        model_q[1] = `REG_MODE_RST;
        reset_model_bank();
        repeat (4) @(posedge i_clk);
        i_arst_n <= 1'b1;

        // reset state and soft-reset release
        err_start = errors;
        @(negedge i_clk);
        check_val("o_rst_n", {7'b0, o_rst_n}, 8'h00);
        check_regs();
        issue(1'b0, 1'b1, `REG_ADDR_MODE, 8'h11, 3'b001, 8'h00, 8'h00);
        wait_rst(1'b1);
        model_run = 1'b1;
        issue(1'b1, 1'b0, `REG_ADDR_CONFIG1, 8'h00, 3'b001, 8'h00, 8'h00);
        issue(1'b1, 1'b0, `REG_ADDR_CONFIG2, 8'h00, 3'b001, 8'h00, 8'h00);
        end_test("reset_state", err_start);

        // one mode enable at a time
        err_start = errors;
        for (int m = 0; m < 3; m++) begin
            acc = 3'b100 >> m;
            for (int i = 0; i < 7; i++) begin
                r = $random(seed);
                d = r[7:0];
                if (reg_addrs[i] == `REG_ADDR_MODE) begin
                    d[0] = 1'b1;
                end
                issue(1'b0, 1'b1, reg_addrs[i], d, acc, 8'h00, 8'h00);
                issue(1'b1, 1'b0, reg_addrs[i], 8'h00, acc, 8'h00, 8'h00);
            end
        end
        end_test("permissions", err_start);

        // device ID and unmapped reads before random traffic
        err_start = errors;
        for (int m = 0; m < 3; m++) begin
            issue(1'b1, 1'b0, `REG_ADDR_DEVICE_ID, 8'h00, 3'b100 >> m, 8'h00, 8'h00);
        end
        issue(1'b1, 1'b1, 7'h05, 8'h5A, 3'b111, 8'h00, 8'h00);
        issue(1'b1, 1'b1, 7'h7F, 8'hC3, 3'b111, 8'h00, 8'h00);
        for (int i = 0; i < 40; i++) begin
            r = $random(seed);
            a = all_addrs[r[3:0]];
            d = r[23:16];
            if (a == `REG_ADDR_MODE) begin
                d[0] = 1'b1;
            end
            issue(r[4], r[5], a, d, r[8:6], 8'h00, 8'h00);
        end
        end_test("read_path", err_start);

        // event set and write-1 clear where the set wins
        err_start = errors;
        issue(1'b0, 1'b0, 7'h00, 8'h00, 3'b001, 8'h5A, 8'h81);
        issue(1'b1, 1'b1, `REG_ADDR_STATUS1, 8'h0F, 3'b001, 8'h00, 8'h00);
        issue(1'b1, 1'b1, `REG_ADDR_STATUS1, 8'hF0, 3'b001, 8'h10, 8'h00);
        issue(1'b1, 1'b1, `REG_ADDR_STATUS2, 8'h01, 3'b001, 8'h00, 8'h00);
        issue(1'b1, 1'b1, `REG_ADDR_STATUS2, 8'h80, 3'b100, 8'h00, 8'h00);
        end_test("status", err_start);

        // soft reset keeps the mode register
        err_start = errors;
        issue(1'b0, 1'b1, `REG_ADDR_CONFIG1, 8'h66, 3'b010, 8'h00, 8'h00);
        issue(1'b0, 1'b1, `REG_ADDR_MODE, 8'h20, 3'b001, 8'h00, 8'h00);
        wait_rst(1'b0);
        issue(1'b1, 1'b0, `REG_ADDR_MODE, 8'h00, 3'b001, 8'h00, 8'h00);
        issue(1'b0, 1'b1, `REG_ADDR_MODE, 8'h21, 3'b001, 8'h00, 8'h00);
        wait_rst(1'b1);
        model_run = 1'b1;
        issue(1'b1, 1'b0, `REG_ADDR_CONFIG1, 8'h00, 3'b001, 8'h00, 8'h00);
        end_test("soft_reset", err_start);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+hdl
hdl/reg_bus_pkg.sv
hdl/reg_map_pkg.sv
hdl/reg_reset_merge.sv
hdl/reg_rw_cell.sv
hdl/reg_rwc_cell.sv
hdl/reg_read_mux.sv
hdl/reg_bank_top.sv
bench/tb_reg_bank.sv

/* run_sim.sh */
#!/bin/sh
# build and run the register bank testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -f list.f --top-module tb_reg_bank -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    && cat sim.log \
    && test -s sim.log \
    && ! grep -q "CHECKS FAILED" sim.log \
    && echo "simulation passed" \
    || { [ -f sim.log ] && cat sim.log; echo "simulation failed"; exit 1; }
